// File: list.f
+incdir+tests
common/mips_pkg.sv
alu/alu.sv
alu/hilo_regs.sv
source/instr_decoder.sv
source/exec_stage.sv
source/exec_unit.sv
tests/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - common/mips_pkg.sv
      - alu/alu.sv
      - alu/hilo_regs.sv
      - source/instr_decoder.sv
      - source/exec_stage.sv
      - source/exec_unit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/exec_unit_tb.sv

// File: tests/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Two's complement less-than, built from the sign bits and an unsigned compare
function automatic logic signed_less(input mips_pkg::word_t x, input mips_pkg::word_t y);
    return (x[31] != y[31]) ? x[31] : (x < y);
endfunction

// Runs one instruction against the model HI/LO, which it updates in place
function automatic void exec_ref(
    input  mips_pkg::instr_u ins,
    input  mips_pkg::word_t  rs,
    input  mips_pkg::word_t  rt,
    inout  mips_pkg::word_t  hi,
    inout  mips_pkg::word_t  lo,
    output mips_pkg::word_t  res,
    output logic             bad
);
    mips_pkg::word_t simm;
    mips_pkg::word_t zimm;
    mips_pkg::word_t mag_a;
    mips_pkg::word_t mag_b;
    logic [4:0]      sh;

    simm = {{16{ins.i_fields.imm[15]}}, ins.i_fields.imm};
    zimm = {16'h0000, ins.i_fields.imm};
    res  = '0;
    bad  = 1'b0;
    sh   = ins.r_fields.funct[2] ? rs[4:0] : ins.r_fields.shamt;  // Variable forms use rs
    case (ins.r_fields.opcode)
        mips_pkg::OPC_RTYPE: begin
            case (ins.r_fields.funct)
                mips_pkg::FN_AND:   res = rs & rt;
                mips_pkg::FN_OR:    res = rs | rt;
                mips_pkg::FN_XOR:   res = rs ^ rt;
                mips_pkg::FN_ADDU:  res = rs + rt;
                mips_pkg::FN_SUBU:  res = rs - rt;
                mips_pkg::FN_SLT:   res = {31'b0, signed_less(rs, rt)};
                mips_pkg::FN_SLTU:  res = {31'b0, rs < rt};
                mips_pkg::FN_SLL, mips_pkg::FN_SLLV: res = rt << sh;
                mips_pkg::FN_SRL, mips_pkg::FN_SRLV: res = rt >> sh;
                mips_pkg::FN_SRA, mips_pkg::FN_SRAV:
                    res = (rt >> sh) | ({32{rt[31]}} & ~(32'hffff_ffff >> sh));  // Sign fill
                mips_pkg::FN_JR:    res = rs;
                mips_pkg::FN_MFHI:  res = hi;
                mips_pkg::FN_MFLO:  res = lo;
                mips_pkg::FN_MTHI:  hi = rs;
                mips_pkg::FN_MTLO:  lo = rs;
                mips_pkg::FN_MULTU: {hi, lo} = {32'b0, rs} * {32'b0, rt};
                mips_pkg::FN_MULT:  {hi, lo} = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};
                mips_pkg::FN_DIVU: begin
                    if (rt != '0) begin
                        lo = rs / rt;
                        hi = rs % rt;
                    end
                end
                mips_pkg::FN_DIV: begin
                    if (rt != '0) begin
                        mag_a = rs[31] ? -rs : rs;
                        mag_b = rt[31] ? -rt : rt;
                        lo    = (rs[31] ^ rt[31]) ? -(mag_a / mag_b) : mag_a / mag_b;
                        hi    = rs[31] ? -(mag_a % mag_b) : mag_a % mag_b;  // Dividend sign
                    end
                end
                default:            bad = 1'b1;
            endcase
        end
        mips_pkg::OPC_REGIMM: begin
            case (ins.i_fields.rt)
                mips_pkg::RT_BLTZ: res = signed_less(rs, 32'd0) ? 32'd0 : 32'd1;  // 0 when taken
                mips_pkg::RT_BGEZ: res = signed_less(rs, 32'd0) ? 32'd1 : 32'd0;
                default:           bad = 1'b1;
            endcase
        end
        mips_pkg::OPC_BNE:   res = (rs != rt) ? 32'd0 : 32'd1;
        mips_pkg::OPC_BLEZ:  res = signed_less(32'd0, rs) ? 32'd1 : 32'd0;
        mips_pkg::OPC_BGTZ:  res = signed_less(32'd0, rs) ? 32'd0 : 32'd1;
        mips_pkg::OPC_ADDIU: res = rs + simm;
        mips_pkg::OPC_SLTI:  res = {31'b0, signed_less(rs, simm)};
        mips_pkg::OPC_SLTIU: res = {31'b0, rs < simm};
        mips_pkg::OPC_ANDI:  res = rs & zimm;
        mips_pkg::OPC_ORI:   res = rs | zimm;
        mips_pkg::OPC_XORI:  res = rs ^ zimm;
        default:             bad = 1'b1;
    endcase
endfunction

`endif

// File: tests/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;

    `include "exec_ref_model.svh"

    localparam int NUM_TESTS   = 6;
    localparam int NUM_INSTR   = 52 + 30 + 26 + 20 + 24 + 6;
    localparam int CYCLE_LIMIT = NUM_INSTR + 2 * NUM_TESTS + 50;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             in_valid;
    mips_pkg::instr_u instr;
    mips_pkg::word_t  rs_data;
    mips_pkg::word_t  rt_data;
    logic             out_valid;
    mips_pkg::word_t  result;
    logic             zero;
    logic             illegal;
    mips_pkg::word_t  hi;
    mips_pkg::word_t  lo;

    mips_pkg::word_t  exp_res_q[$];
    mips_pkg::word_t  exp_hi_q[$];
    mips_pkg::word_t  exp_lo_q[$];
    logic             exp_ill_q[$];
    mips_pkg::word_t  exp_res;
    mips_pkg::word_t  model_hi;
    mips_pkg::word_t  model_lo;
    mips_pkg::word_t  a_val;
    mips_pkg::word_t  b_val;
    mips_pkg::instr_u cur;
    logic [5:0]       code;
    logic [4:0]       sh_amt;
    integer           seed;
    int               issued = 0;
    int               checks = 0;
    int               errors = 0;
    int               cycles = 0;
    int               base_issued = 0;
    int               base_errors = 0;

    always #20 clk = ~clk;

    exec_unit u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .out_valid (out_valid),
        .result    (result),
        .zero      (zero),
        .illegal   (illegal),
        .hi        (hi),
        .lo        (lo)
    );

    function automatic mips_pkg::instr_u rtype(input logic [5:0] funct, input logic [4:0] sa);
        return {mips_pkg::OPC_RTYPE, 5'd4, 5'd5, 5'd6, sa, funct};
    endfunction

    function automatic mips_pkg::instr_u itype(input logic [5:0] opc, input logic [4:0] rtf,
                                               input logic [15:0] imm);
        return {opc, 5'd4, rtf, imm};
    endfunction

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s is %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s is %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic issue(input mips_pkg::instr_u w, input mips_pkg::word_t rs,
                         input mips_pkg::word_t rt);
        mips_pkg::word_t res;
        logic            bad;
        @(negedge clk);
        in_valid = 1'b1;
        instr    = w;
        rs_data  = rs;
        rt_data  = rt;
        exec_ref(w, rs, rt, model_hi, model_lo, res, bad);
        exp_res_q.push_back(res);
        exp_hi_q.push_back(model_hi);  // HI/LO as they stand after this instruction
        exp_lo_q.push_back(model_lo);
        exp_ill_q.push_back(bad);
        issued++;
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_res_q.size() != 0) @(negedge clk);
        $display("%-8s %0d instructions, %0d errors", name, issued - base_issued,
                 errors - base_errors);
        base_issued = issued;
        base_errors = errors;
    endtask

    // Outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_res_q.size() == 0) begin
                $display("out_valid pulsed with no instruction in flight");
                errors++;
            end else begin
                exp_res = exp_res_q.pop_front();
                check_word("result", result, exp_res);
                check_flag("zero", zero, exp_res == '0);
                check_flag("illegal", illegal, exp_ill_q.pop_front());
                check_word("hi", hi, exp_hi_q.pop_front());
                check_word("lo", lo, exp_lo_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        seed     = 12;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        rs_data  = '0;
        rt_data  = '0;
        model_hi = '0;
        model_lo = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 13; k++) begin
                a_val = $random(seed);
                b_val = $random(seed);
                case (k)
                    0:       code = mips_pkg::FN_AND;
                    1:       code = mips_pkg::FN_OR;
                    2:       code = mips_pkg::FN_XOR;
                    3:       code = mips_pkg::FN_ADDU;
                    4:       code = mips_pkg::FN_SUBU;
                    5:       code = mips_pkg::FN_SLT;
                    6:       code = mips_pkg::FN_SLTU;
                    7:       code = mips_pkg::OPC_ANDI;
                    8:       code = mips_pkg::OPC_ORI;
                    9:       code = mips_pkg::OPC_XORI;
                    10:      code = mips_pkg::OPC_ADDIU;
                    11:      code = mips_pkg::OPC_SLTI;
                    default: code = mips_pkg::OPC_SLTIU;
                endcase
                cur = (k < 7) ? rtype(code, 5'd0) : itype(code, 5'd5, b_val[15:0]);
                issue(cur, a_val, b_val);
            end
        end
        finish_test("arith");

        for (int r = 0; r < 5; r++) begin
            for (int k = 0; k < 6; k++) begin
                a_val = $random(seed);
                b_val = $random(seed);
                if (r >= 2) b_val[31] = 1'b1;  // Negative b for SRA and SRAV
                sh_amt = (r == 0) ? 5'd0 : (r == 1) ? 5'd31 : a_val[9:5];
                a_val[4:0] = (k < 3) ? ~sh_amt : sh_amt;  // rs bits differ from the shamt field
                case (k)
                    0:       code = mips_pkg::FN_SLL;
                    1:       code = mips_pkg::FN_SRL;
                    2:       code = mips_pkg::FN_SRA;
                    3:       code = mips_pkg::FN_SLLV;
                    4:       code = mips_pkg::FN_SRLV;
                    default: code = mips_pkg::FN_SRAV;
                endcase
                issue(rtype(code, (k < 3) ? sh_amt : ~sh_amt), a_val, b_val);
            end
        end
        finish_test("shift");

        for (int r = 0; r < 6; r++) begin
            for (int k = 0; k < 4; k++) begin
                a_val = $random(seed);
                b_val = $random(seed);
                if (r >= 3) a_val[31] = 1'b1;
                if (r == 4) b_val[31] = 1'b1;
                if (r == 5) b_val = $signed(b_val) >>> 24;  // Small divisor
                case (k)
                    0:       code = mips_pkg::FN_MULT;
                    1:       code = mips_pkg::FN_MULTU;
                    2:       code = mips_pkg::FN_DIV;
                    default: code = mips_pkg::FN_DIVU;
                endcase
                issue(rtype(code, 5'd0), a_val, b_val);
            end
        end
        a_val = $random(seed);
        issue(rtype(mips_pkg::FN_DIV, 5'd0), a_val, '0);
        issue(rtype(mips_pkg::FN_DIVU, 5'd0), ~a_val, '0);
        finish_test("muldiv");

        // MFHI and MFLO right behind MULT see the new HI/LO
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 10; k++) begin
                a_val = $random(seed);
                b_val = $random(seed);
                case (k)
                    0:       code = mips_pkg::FN_MTHI;
                    1:       code = mips_pkg::FN_MTLO;
                    2:       code = mips_pkg::FN_MFHI;
                    3:       code = mips_pkg::FN_MFLO;
                    4:       code = mips_pkg::FN_MULT;
                    5:       code = mips_pkg::FN_MFHI;
                    6:       code = mips_pkg::FN_MFLO;
                    7:       code = mips_pkg::FN_MULTU;
                    8:       code = mips_pkg::FN_MFLO;
                    default: code = mips_pkg::FN_MFHI;
                endcase
                issue(rtype(code, 5'd0), a_val, b_val);
            end
        end
        finish_test("hilo");

        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < 5; k++) begin
                a_val = $random(seed);
                b_val = $random(seed);
                case (j)
                    0:       a_val = '0;
                    1:       a_val = 32'd1 + b_val[7:0];
                    2:       a_val[31] = 1'b1;
                    default: a_val = a_val;
                endcase
                if (!j[0]) b_val = a_val;  // Equal operands for BNE
                case (k)
                    0: cur = itype(mips_pkg::OPC_REGIMM, mips_pkg::RT_BLTZ, b_val[15:0]);
                    1: cur = itype(mips_pkg::OPC_REGIMM, mips_pkg::RT_BGEZ, b_val[15:0]);
                    2: cur = itype(mips_pkg::OPC_BGTZ, 5'd0, b_val[15:0]);
                    3: cur = itype(mips_pkg::OPC_BLEZ, 5'd0, b_val[15:0]);
                    default: cur = itype(mips_pkg::OPC_BNE, 5'd5, b_val[15:0]);
                endcase
                issue(cur, a_val, b_val);
            end
            issue(rtype(mips_pkg::FN_JR, 5'd0), $random(seed), $random(seed));
        end
        finish_test("branch");

        for (int r = 0; r < 3; r++) begin
            a_val = $random(seed);
            b_val = $random(seed);
            issue(itype(6'h3f, 5'd5, b_val[15:0]), a_val, b_val);  // Unknown opcode
            issue(rtype(6'h3f, 5'd0), a_val, b_val);              // Unknown funct
        end
        finish_test("illegal");

        if (exp_res_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_res_q.size());
            errors++;
        end
        $display("Totals: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  mips_pkg::instr_u instr,
    input  mips_pkg::word_t  rs_data,
    input  mips_pkg::word_t  rt_data,
    output logic             out_valid,
    output mips_pkg::word_t  result,
    output logic             zero,
    output logic             illegal,
    output mips_pkg::word_t  hi,
    output mips_pkg::word_t  lo
);

    logic              dec_valid;
    mips_pkg::alu_op_e dec_op;
    mips_pkg::word_t   dec_a;
    mips_pkg::word_t   dec_b;
    logic [4:0]        dec_shamt;
    logic              dec_illegal;

    instr_decoder u_decoder (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .instr       (instr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_shamt   (dec_shamt),
        .dec_illegal (dec_illegal)
    );

    exec_stage u_exec (
        .clk         (clk),
        .arst_n      (arst_n),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_shamt   (dec_shamt),
        .dec_illegal (dec_illegal),
        .out_valid   (out_valid),
        .result      (result),
        .zero        (zero),
        .illegal     (illegal),
        .hi          (hi),
        .lo          (lo)
    );

endmodule

// File: source/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dec_valid,
    input  mips_pkg::alu_op_e dec_op,
    input  mips_pkg::word_t   dec_a,
    input  mips_pkg::word_t   dec_b,
    input  logic [4:0]        dec_shamt,
    input  logic              dec_illegal,
    output logic              out_valid,
    output mips_pkg::word_t   result,
    output logic              zero,
    output logic              illegal,
    output mips_pkg::word_t   hi,
    output mips_pkg::word_t   lo
);

    mips_pkg::word_t alu_y;
    mips_pkg::word_t hi_next;
    mips_pkg::word_t lo_next;

    alu u_alu (
        .op      (dec_op),
        .a       (dec_a),
        .b       (dec_b),
        .shamt   (dec_shamt),
        .hi      (hi),        // Value written at the end of the last cycle
        .lo      (lo),
        .y       (alu_y),
        .hi_next (hi_next),
        .lo_next (lo_next)
    );

    hilo_regs u_hilo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_valid (dec_valid && !dec_illegal),  // Illegal words leave HI/LO alone
        .op       (dec_op),
        .divisor  (dec_b),
        .hi_next  (hi_next),
        .lo_next  (lo_next),
        .hi       (hi),
        .lo       (lo)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= dec_valid;
            if (dec_valid) begin
                result  <= dec_illegal ? '0 : alu_y;
                illegal <= dec_illegal;
            end
        end
    end

    assign zero = (result == '0);  // Also the branch-taken flag

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  mips_pkg::instr_u   instr,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    output logic               dec_valid,
    output mips_pkg::alu_op_e  dec_op,
    output mips_pkg::word_t    dec_a,
    output mips_pkg::word_t    dec_b,
    output logic [4:0]         dec_shamt,
    output logic               dec_illegal
);

    mips_pkg::alu_op_e op_d;
    logic              illegal_d;
    logic              use_imm;      // Operand B from the immediate
    logic              imm_sext;     // Sign extend, else zero extend
    mips_pkg::word_t   imm_ext;

    always_comb begin
        op_d      = mips_pkg::op_and;
        illegal_d = 1'b0;
        use_imm   = 1'b0;
        imm_sext  = 1'b0;
        case (instr.r_fields.opcode)
            mips_pkg::OPC_RTYPE: begin
                case (instr.r_fields.funct)
                    mips_pkg::FN_SLL:   op_d = mips_pkg::op_sll;
                    mips_pkg::FN_SRL:   op_d = mips_pkg::op_srl;
                    mips_pkg::FN_SRA:   op_d = mips_pkg::op_sra;
                    mips_pkg::FN_SLLV:  op_d = mips_pkg::op_sllv;
                    mips_pkg::FN_SRLV:  op_d = mips_pkg::op_srlv;
                    mips_pkg::FN_SRAV:  op_d = mips_pkg::op_srav;
                    mips_pkg::FN_JR:    op_d = mips_pkg::op_jr;
                    mips_pkg::FN_MFHI:  op_d = mips_pkg::op_mfhi;
                    mips_pkg::FN_MTHI:  op_d = mips_pkg::op_mthi;
                    mips_pkg::FN_MFLO:  op_d = mips_pkg::op_mflo;
                    mips_pkg::FN_MTLO:  op_d = mips_pkg::op_mtlo;
                    mips_pkg::FN_MULT:  op_d = mips_pkg::op_mult;
                    mips_pkg::FN_MULTU: op_d = mips_pkg::op_multu;
                    mips_pkg::FN_DIV:   op_d = mips_pkg::op_div;
                    mips_pkg::FN_DIVU:  op_d = mips_pkg::op_divu;
                    mips_pkg::FN_ADDU:  op_d = mips_pkg::op_addu;
                    mips_pkg::FN_SUBU:  op_d = mips_pkg::op_subu;
                    mips_pkg::FN_AND:   op_d = mips_pkg::op_and;
                    mips_pkg::FN_OR:    op_d = mips_pkg::op_or;
                    mips_pkg::FN_XOR:   op_d = mips_pkg::op_xor;
                    mips_pkg::FN_SLT:   op_d = mips_pkg::op_slt;
                    mips_pkg::FN_SLTU:  op_d = mips_pkg::op_sltu;
                    default:            illegal_d = 1'b1;  // Unknown funct
                endcase
            end
            mips_pkg::OPC_REGIMM: begin
                case (instr.i_fields.rt)  // Branch kind sits in rt
                    mips_pkg::RT_BLTZ: op_d = mips_pkg::op_bltz;
                    mips_pkg::RT_BGEZ: op_d = mips_pkg::op_bgez;
                    default:           illegal_d = 1'b1;
                endcase
            end
            mips_pkg::OPC_BNE:  op_d = mips_pkg::op_bne;
            mips_pkg::OPC_BLEZ: op_d = mips_pkg::op_blez;
            mips_pkg::OPC_BGTZ: op_d = mips_pkg::op_bgtz;
            mips_pkg::OPC_ADDIU: begin
                op_d     = mips_pkg::op_addu;
                use_imm  = 1'b1;
                imm_sext = 1'b1;
            end
            mips_pkg::OPC_SLTI: begin
                op_d     = mips_pkg::op_slt;
                use_imm  = 1'b1;
                imm_sext = 1'b1;
            end
            mips_pkg::OPC_SLTIU: begin
                op_d     = mips_pkg::op_sltu;  // Unsigned compare, signed immediate
                use_imm  = 1'b1;
                imm_sext = 1'b1;
            end
            mips_pkg::OPC_ANDI: begin
                op_d    = mips_pkg::op_and;
                use_imm = 1'b1;
            end
            mips_pkg::OPC_ORI: begin
                op_d    = mips_pkg::op_or;
                use_imm = 1'b1;
            end
            mips_pkg::OPC_XORI: begin
                op_d    = mips_pkg::op_xor;
                use_imm = 1'b1;
            end
            default: illegal_d = 1'b1;  // Unknown opcode
        endcase
    end

    assign imm_ext = imm_sext ? {{16{instr.i_fields.imm[15]}}, instr.i_fields.imm}
                              : {16'b0, instr.i_fields.imm};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // Decoded fields load with each strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec_op      <= op_d;
            dec_illegal <= illegal_d;
            dec_a       <= rs_data;
            dec_b       <= use_imm ? imm_ext : rt_data;
            dec_shamt   <= instr.r_fields.shamt;
        end
    end

endmodule

// File: alu/hilo_regs.sv
`timescale 1ns/1ps

module hilo_regs (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_valid,
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::word_t   divisor,
    input  mips_pkg::word_t   hi_next,
    input  mips_pkg::word_t   lo_next,
    output mips_pkg::word_t   hi,
    output mips_pkg::word_t   lo
);

    logic is_div;
    logic wr_en;

    assign is_div = (op == mips_pkg::op_div) || (op == mips_pkg::op_divu);

    // Divide by zero keeps the old HI/LO
    assign wr_en = wr_valid &&
                   ((op == mips_pkg::op_mult) || (op == mips_pkg::op_multu) ||
                    (op == mips_pkg::op_mthi) || (op == mips_pkg::op_mtlo) ||
                    (is_div && (divisor != '0)));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (wr_en) begin
            hi <= hi_next;
            lo <= lo_next;
        end
    end

endmodule

// File: alu/alu.sv
`timescale 1ns/1ps

module alu (
    input  mips_pkg::alu_op_e op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  mips_pkg::word_t   hi,
    input  mips_pkg::word_t   lo,
    output mips_pkg::word_t   y,
    output mips_pkg::word_t   hi_next,
    output mips_pkg::word_t   lo_next
);

    logic [63:0]     prod_u;
    logic [63:0]     prod_s;
    mips_pkg::word_t quot_s;
    mips_pkg::word_t rem_s;
    mips_pkg::word_t quot_u;
    mips_pkg::word_t rem_u;
    logic            a_neg;
    logic            a_zero;

    assign prod_u = {32'b0, a} * {32'b0, b};
    assign prod_s = $signed(a) * $signed(b);  // Operands sign extended to 64 bits

    // Truncates toward zero, remainder follows the dividend
    assign quot_s = $signed(a) / $signed(b);
    assign rem_s  = $signed(a) % $signed(b);
    assign quot_u = a / b;
    assign rem_u  = a % b;

    assign a_neg  = a[31];
    assign a_zero = (a == '0);

    always_comb begin
        y = '0;
        case (op)
            mips_pkg::op_and:   y = a & b;
            mips_pkg::op_or:    y = a | b;
            mips_pkg::op_xor:   y = a ^ b;
            mips_pkg::op_addu:  y = a + b;
            mips_pkg::op_subu:  y = a - b;
            mips_pkg::op_sltu:  y = {31'b0, a < b};
            mips_pkg::op_slt:   y = {31'b0, $signed(a) < $signed(b)};
            mips_pkg::op_sll:   y = b << shamt;
            mips_pkg::op_srl:   y = b >> shamt;
            mips_pkg::op_sra:   y = $signed(b) >>> shamt;
            mips_pkg::op_sllv:  y = b << a[4:0];  // Shift amount from rs
            mips_pkg::op_srlv:  y = b >> a[4:0];
            mips_pkg::op_srav:  y = $signed(b) >>> a[4:0];
            mips_pkg::op_mfhi:  y = hi;
            mips_pkg::op_mflo:  y = lo;
            mips_pkg::op_jr:    y = a;
            // Branches give 0 when taken
            mips_pkg::op_bltz:  y = {31'b0, !a_neg};
            mips_pkg::op_bgez:  y = {31'b0, a_neg};
            mips_pkg::op_bgtz:  y = {31'b0, a_neg || a_zero};
            mips_pkg::op_blez:  y = {31'b0, !(a_neg || a_zero)};
            mips_pkg::op_bne:   y = {31'b0, a == b};
            default:            y = '0;  // MULT, DIV and MT ops write HI/LO only
        endcase
    end

    always_comb begin
        hi_next = hi;
        lo_next = lo;
        case (op)
            mips_pkg::op_mult: begin
                hi_next = prod_s[63:32];
                lo_next = prod_s[31:0];
            end
            mips_pkg::op_multu: begin
                hi_next = prod_u[63:32];
                lo_next = prod_u[31:0];
            end
            mips_pkg::op_div: begin
                hi_next = rem_s;
                lo_next = quot_s;
            end
            mips_pkg::op_divu: begin
                hi_next = rem_u;
                lo_next = quot_u;
            end
            mips_pkg::op_mthi: hi_next = a;  // Other half passes through
            mips_pkg::op_mtlo: lo_next = a;
            default: begin
                hi_next = hi;
                lo_next = lo;
            end
        endcase
    end

endmodule

// File: common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [4:0] {
        op_and,
        op_or,
        op_xor,
        op_addu,
        op_subu,
        op_sltu,
        op_slt,
        op_multu,
        op_mult,
        op_sll,
        op_sllv,
        op_sra,
        op_srl,
        op_srav,
        op_srlv,
        op_div,
        op_divu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo,
        op_bltz,
        op_bgez,
        op_bgtz,
        op_blez,
        op_bne,
        op_jr
    } alu_op_e;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same 32-bit word, seen as R-type or I-type
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    // Primary opcodes
    localparam logic [5:0] OPC_RTYPE  = 6'h00;
    localparam logic [5:0] OPC_REGIMM = 6'h01;
    localparam logic [5:0] OPC_BNE    = 6'h05;
    localparam logic [5:0] OPC_BLEZ   = 6'h06;
    localparam logic [5:0] OPC_BGTZ   = 6'h07;
    localparam logic [5:0] OPC_ADDIU  = 6'h09;
    localparam logic [5:0] OPC_SLTI   = 6'h0a;
    localparam logic [5:0] OPC_SLTIU  = 6'h0b;
    localparam logic [5:0] OPC_ANDI   = 6'h0c;
    localparam logic [5:0] OPC_ORI    = 6'h0d;
    localparam logic [5:0] OPC_XORI   = 6'h0e;

    // REGIMM codes, carried in the rt field
    localparam logic [4:0] RT_BLTZ = 5'h00;
    localparam logic [4:0] RT_BGEZ = 5'h01;

    // R-type funct codes
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

endpackage
